// ==== build.f ====
+incdir+include
logic/mips_pkg.sv
logic/fetch_stage.sv
logic/inst_decoder.sv
logic/decode_stage.sv
logic/reg_file.sv
logic/execute_stage.sv
logic/mips_core_top.sv
testbench/tb_clock_gen.sv
testbench/tb_mips_core.sv

// ==== include/mips_consts.svh ====
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

`define MIPS_WORD_W       32
`define MIPS_REG_ADDR_W   5
`define MIPS_REG_NUM      32
`define MIPS_ALU_OP_W     4

// alu operation codes
`define MIPS_ALU_NOP      4'h0
`define MIPS_ALU_OR       4'h1
`define MIPS_ALU_AND      4'h2
`define MIPS_ALU_XOR      4'h3
`define MIPS_ALU_NOR      4'h4
`define MIPS_ALU_SLL      4'h5
`define MIPS_ALU_SRL      4'h6
`define MIPS_ALU_SRA      4'h7
`define MIPS_ALU_ADD      4'h8
`define MIPS_ALU_SUB      4'h9
`define MIPS_ALU_SLT      4'ha
`define MIPS_ALU_SLTU     4'hb

// primary opcodes
`define MIPS_OP_SPECIAL   6'b000000
`define MIPS_OP_ADDI      6'b001000
`define MIPS_OP_ADDIU     6'b001001
`define MIPS_OP_SLTI      6'b001010
`define MIPS_OP_SLTIU     6'b001011
`define MIPS_OP_ANDI      6'b001100
`define MIPS_OP_ORI       6'b001101
`define MIPS_OP_XORI      6'b001110
`define MIPS_OP_LUI       6'b001111

// function codes under SPECIAL
`define MIPS_FN_SLL       6'b000000
`define MIPS_FN_SRL       6'b000010
`define MIPS_FN_SRA       6'b000011
`define MIPS_FN_SLLV      6'b000100
`define MIPS_FN_SRLV      6'b000110
`define MIPS_FN_SRAV      6'b000111
`define MIPS_FN_ADD       6'b100000
`define MIPS_FN_ADDU      6'b100001
`define MIPS_FN_SUB       6'b100010
`define MIPS_FN_SUBU      6'b100011
`define MIPS_FN_AND       6'b100100
`define MIPS_FN_OR        6'b100101
`define MIPS_FN_XOR       6'b100110
`define MIPS_FN_NOR       6'b100111
`define MIPS_FN_SLT       6'b101010
`define MIPS_FN_SLTU      6'b101011

// sll r0, r0, 0
`define MIPS_NOP_INST     32'h0000_0000

`endif

// ==== logic/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
    input  logic                clk,
    input  logic                rst_n_i,
    input  mips_pkg::if_id_t    if_id_i,
    output mips_pkg::reg_addr_t rf_raddr1_o,
    output mips_pkg::reg_addr_t rf_raddr2_o,
    input  mips_pkg::word_t     rf_rdata1_i,
    input  mips_pkg::word_t     rf_rdata2_i,
    input  mips_pkg::wb_t       ex_fwd_i,
    input  mips_pkg::wb_t       wb_fwd_i,
    output mips_pkg::id_ex_t    id_ex_o
);
    import mips_pkg::*;

    decoded_t  dec;
    word_t     op1;
    word_t     op2;
    logic      valid_q;
    logic      wreg_q;
    alu_op_t   alu_op_q;
    word_t     op1_q;
    word_t     op2_q;
    reg_addr_t wd_q;

    // execute result wins over writeback and both win over the register file
    function automatic word_t pick_operand(
        input logic      rd_en,
        input reg_addr_t addr,
        input word_t     rf_word,
        input word_t     imm,
        input wb_t       ex_fwd,
        input wb_t       wb_fwd
    );
        word_t res;
        if (!rd_en) begin
            res = imm;
        end else if (ex_fwd.wreg && (ex_fwd.wd == addr)) begin
            res = ex_fwd.wdata;
        end else if (wb_fwd.wreg && (wb_fwd.wd == addr)) begin
            res = wb_fwd.wdata;
        end else begin
            res = rf_word;
        end
        return res;
    endfunction

    inst_decoder u_inst_decoder (
        .inst_i    (if_id_i.inst),
        .decoded_o (dec)
    );

    assign rf_raddr1_o = dec.reg1_addr;
    assign rf_raddr2_o = dec.reg2_addr;

    assign op1 = pick_operand(dec.reg1_read, dec.reg1_addr, rf_rdata1_i, dec.imm,
                              ex_fwd_i, wb_fwd_i);
    assign op2 = pick_operand(dec.reg2_read, dec.reg2_addr, rf_rdata2_i, dec.imm,
                              ex_fwd_i, wb_fwd_i);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
            wreg_q  <= 1'b0;
        end else begin
            valid_q <= if_id_i.valid;
            wreg_q  <= if_id_i.valid & dec.wreg;
        end
    end

    always_ff @(posedge clk) begin
        alu_op_q <= dec.alu_op;
        op1_q    <= op1;
        op2_q    <= op2;
        wd_q     <= dec.wd;
    end

    assign id_ex_o = '{valid: valid_q, alu_op: alu_op_q, op1: op1_q, op2: op2_q,
                       wd: wd_q, wreg: wreg_q};

endmodule

// ==== logic/execute_stage.sv ====
`timescale 1ns/1ps

`include "mips_consts.svh"

module execute_stage (
    input  logic              clk,
    input  logic              rst_n_i,
    input  mips_pkg::id_ex_t  id_ex_i,
    output mips_pkg::wb_t     ex_fwd_o,
    output mips_pkg::wb_t     wb_res_o
);
    import mips_pkg::*;

    word_t      op1;
    word_t      op2;
    logic [4:0] sa;
    word_t      result;
    logic       wreg_q;
    reg_addr_t  wd_q;
    word_t      wdata_q;

    assign op1 = id_ex_i.op1;
    assign op2 = id_ex_i.op2;
    // shift amount always from op1
    assign sa  = op1[4:0];

    always_comb begin
        case (id_ex_i.alu_op)
            `MIPS_ALU_OR:   result = op1 | op2;
            `MIPS_ALU_AND:  result = op1 & op2;
            `MIPS_ALU_XOR:  result = op1 ^ op2;
            `MIPS_ALU_NOR:  result = ~(op1 | op2);
            `MIPS_ALU_SLL:  result = op2 << sa;
            `MIPS_ALU_SRL:  result = op2 >> sa;
            `MIPS_ALU_SRA:  result = word_t'($signed(op2) >>> sa);
            `MIPS_ALU_ADD:  result = op1 + op2;
            `MIPS_ALU_SUB:  result = op1 - op2;
            `MIPS_ALU_SLT:  result = {31'd0, $signed(op1) < $signed(op2)};
            `MIPS_ALU_SLTU: result = {31'd0, op1 < op2};
            default:        result = '0;
        endcase
    end

    // bubbles never forward or commit
    assign ex_fwd_o = '{wreg: id_ex_i.valid & id_ex_i.wreg, wd: id_ex_i.wd, wdata: result};

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wreg_q <= 1'b0;
        end else begin
            wreg_q <= ex_fwd_o.wreg;
        end
    end

    always_ff @(posedge clk) begin
        wd_q    <= ex_fwd_o.wd;
        wdata_q <= ex_fwd_o.wdata;
    end

    assign wb_res_o = '{wreg: wreg_q, wd: wd_q, wdata: wdata_q};

endmodule

// ==== logic/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage (
    input  logic             clk,
    input  logic             rst_n_i,
    output logic             wb_cyc_o,
    output logic             wb_stb_o,
    output mips_pkg::word_t  wb_adr_o,
    input  mips_pkg::inst_t  wb_dat_i,
    input  logic             wb_ack_i,
    output mips_pkg::if_id_t if_id_o
);
    import mips_pkg::*;

    logic  req_q;
    word_t pc_q;
    logic  valid_q;
    word_t inst_pc_q;
    inst_t inst_q;
    logic  xfer_done;

    // read request stays up for the whole run
    assign wb_cyc_o = req_q;
    assign wb_stb_o = req_q;
    assign wb_adr_o = pc_q;

    assign xfer_done = req_q & wb_ack_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            req_q   <= 1'b0;
            pc_q    <= '0;
            valid_q <= 1'b0;
        end else begin
            req_q   <= 1'b1;
            // a wait state becomes a bubble
            valid_q <= xfer_done;
            if (xfer_done) begin
                pc_q <= pc_q + 32'd4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (xfer_done) begin
            inst_pc_q <= pc_q;
            inst_q    <= wb_dat_i;
        end
    end

    assign if_id_o = '{valid: valid_q, pc: inst_pc_q, inst: inst_q};

endmodule

// ==== logic/inst_decoder.sv ====
`timescale 1ns/1ps

`include "mips_consts.svh"

module inst_decoder (
    input  mips_pkg::inst_t    inst_i,
    output mips_pkg::decoded_t decoded_o
);
    import mips_pkg::*;

    logic [5:0]  opcode;
    logic [5:0]  funct;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   rd;
    logic [4:0]  shamt;
    logic [15:0] imm16;
    logic        known;
    decoded_t    dec;

    assign opcode = inst_i[31:26];
    assign rs     = inst_i[25:21];
    assign rt     = inst_i[20:16];
    assign rd     = inst_i[15:11];
    assign shamt  = inst_i[10:6];
    assign funct  = inst_i[5:0];
    assign imm16  = inst_i[15:0];

    always_comb begin
        known         = 1'b0;
        dec.alu_op    = `MIPS_ALU_NOP;
        dec.reg1_read = 1'b0;
        dec.reg2_read = 1'b0;
        dec.reg1_addr = rs;
        dec.reg2_addr = rt;
        dec.imm       = '0;
        dec.wd        = rd;
        dec.wreg      = 1'b0;

        case (opcode)
            `MIPS_OP_SPECIAL: begin
                case (funct)
                    `MIPS_FN_SLL, `MIPS_FN_SRL, `MIPS_FN_SRA: begin
                        // fixed shift takes its amount as op1
                        known         = (rs == 5'd0);
                        dec.reg2_read = 1'b1;
                        dec.imm       = {27'd0, shamt};
                    end
                    default: begin
                        known         = (shamt == 5'd0);
                        dec.reg1_read = 1'b1;
                        dec.reg2_read = 1'b1;
                    end
                endcase

                case (funct)
                    `MIPS_FN_OR:                   dec.alu_op = `MIPS_ALU_OR;
                    `MIPS_FN_AND:                  dec.alu_op = `MIPS_ALU_AND;
                    `MIPS_FN_XOR:                  dec.alu_op = `MIPS_ALU_XOR;
                    `MIPS_FN_NOR:                  dec.alu_op = `MIPS_ALU_NOR;
                    `MIPS_FN_SLL, `MIPS_FN_SLLV:   dec.alu_op = `MIPS_ALU_SLL;
                    `MIPS_FN_SRL, `MIPS_FN_SRLV:   dec.alu_op = `MIPS_ALU_SRL;
                    `MIPS_FN_SRA, `MIPS_FN_SRAV:   dec.alu_op = `MIPS_ALU_SRA;
                    // add behaves as addu without an overflow trap
                    `MIPS_FN_ADD, `MIPS_FN_ADDU:   dec.alu_op = `MIPS_ALU_ADD;
                    `MIPS_FN_SUB, `MIPS_FN_SUBU:   dec.alu_op = `MIPS_ALU_SUB;
                    `MIPS_FN_SLT:                  dec.alu_op = `MIPS_ALU_SLT;
                    `MIPS_FN_SLTU:                 dec.alu_op = `MIPS_ALU_SLTU;
                    default:                       known      = 1'b0;
                endcase
            end
            `MIPS_OP_ORI, `MIPS_OP_ANDI, `MIPS_OP_XORI: begin
                known         = 1'b1;
                dec.reg1_read = 1'b1;
                dec.imm       = {16'h0000, imm16};
                dec.wd        = rt;
                case (opcode)
                    `MIPS_OP_ORI:  dec.alu_op = `MIPS_ALU_OR;
                    `MIPS_OP_ANDI: dec.alu_op = `MIPS_ALU_AND;
                    default:       dec.alu_op = `MIPS_ALU_XOR;
                endcase
            end
            `MIPS_OP_LUI: begin
                // imm on both operands so the or passes it through
                known      = 1'b1;
                dec.alu_op = `MIPS_ALU_OR;
                dec.imm    = {imm16, 16'h0000};
                dec.wd     = rt;
            end
            `MIPS_OP_ADDI, `MIPS_OP_ADDIU, `MIPS_OP_SLTI, `MIPS_OP_SLTIU: begin
                known         = 1'b1;
                dec.reg1_read = 1'b1;
                dec.imm       = {{16{imm16[15]}}, imm16};
                dec.wd        = rt;
                case (opcode)
                    `MIPS_OP_SLTI:  dec.alu_op = `MIPS_ALU_SLT;
                    `MIPS_OP_SLTIU: dec.alu_op = `MIPS_ALU_SLTU;
                    default:        dec.alu_op = `MIPS_ALU_ADD;
                endcase
            end
            default: begin
                known = 1'b0;
            end
        endcase

        // writes to r0 are dropped here
        dec.wreg = known && (dec.wd != 5'd0);
    end

    assign decoded_o = dec;

endmodule

// ==== logic/mips_core_top.sv ====
`timescale 1ns/1ps

module mips_core_top (
    input  logic                clk,
    input  logic                rst_n_i,
    output logic                wb_cyc_o,
    output logic                wb_stb_o,
    output mips_pkg::word_t     wb_adr_o,
    input  mips_pkg::inst_t     wb_dat_i,
    input  logic                wb_ack_i,
    output logic                commit_we_o,
    output mips_pkg::reg_addr_t commit_addr_o,
    output mips_pkg::word_t     commit_data_o
);
    import mips_pkg::*;

    if_id_t    if_id;
    id_ex_t    id_ex;
    wb_t       ex_fwd;
    wb_t       wb_res;
    reg_addr_t rf_raddr1;
    reg_addr_t rf_raddr2;
    word_t     rf_rdata1;
    word_t     rf_rdata2;

    fetch_stage u_fetch_stage (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .wb_cyc_o (wb_cyc_o),
        .wb_stb_o (wb_stb_o),
        .wb_adr_o (wb_adr_o),
        .wb_dat_i (wb_dat_i),
        .wb_ack_i (wb_ack_i),
        .if_id_o  (if_id)
    );

    decode_stage u_decode_stage (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .if_id_i     (if_id),
        .rf_raddr1_o (rf_raddr1),
        .rf_raddr2_o (rf_raddr2),
        .rf_rdata1_i (rf_rdata1),
        .rf_rdata2_i (rf_rdata2),
        .ex_fwd_i    (ex_fwd),
        .wb_fwd_i    (wb_res),
        .id_ex_o     (id_ex)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .raddr1_i (rf_raddr1),
        .raddr2_i (rf_raddr2),
        .rdata1_o (rf_rdata1),
        .rdata2_o (rf_rdata2),
        .wr_i     (wb_res)
    );

    execute_stage u_execute_stage (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .id_ex_i  (id_ex),
        .ex_fwd_o (ex_fwd),
        .wb_res_o (wb_res)
    );

    // every register write is a commit
    assign commit_we_o   = wb_res.wreg;
    assign commit_addr_o = wb_res.wd;
    assign commit_data_o = wb_res.wdata;

endmodule

// ==== logic/mips_pkg.sv ====
`include "mips_consts.svh"

package mips_pkg;

    typedef logic [`MIPS_WORD_W-1:0]     word_t;
    typedef logic [`MIPS_WORD_W-1:0]     inst_t;
    typedef logic [`MIPS_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`MIPS_ALU_OP_W-1:0]   alu_op_t;

    // fetch to decode
    typedef struct packed {
        logic  valid;
        word_t pc;
        inst_t inst;
    } if_id_t;

    // output of the instruction decoder
    typedef struct packed {
        alu_op_t   alu_op;
        logic      reg1_read;
        logic      reg2_read;
        reg_addr_t reg1_addr;
        reg_addr_t reg2_addr;
        word_t     imm;
        reg_addr_t wd;
        logic      wreg;
    } decoded_t;

    // decode to execute with operands already resolved
    typedef struct packed {
        logic      valid;
        alu_op_t   alu_op;
        word_t     op1;
        word_t     op2;
        reg_addr_t wd;
        logic      wreg;
    } id_ex_t;

    // register write that also serves as a forwarding source
    typedef struct packed {
        logic      wreg;
        reg_addr_t wd;
        word_t     wdata;
    } wb_t;

endpackage

// ==== logic/reg_file.sv ====
`timescale 1ns/1ps

`include "mips_consts.svh"

module reg_file (
    input  logic                clk,
    input  logic                rst_n_i,
    input  mips_pkg::reg_addr_t raddr1_i,
    input  mips_pkg::reg_addr_t raddr2_i,
    output mips_pkg::word_t     rdata1_o,
    output mips_pkg::word_t     rdata2_o,
    input  mips_pkg::wb_t       wr_i
);
    import mips_pkg::*;

    // r0 has no storage
    word_t regs [1:`MIPS_REG_NUM-1];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < `MIPS_REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i.wreg && (wr_i.wd != 5'd0)) begin
            regs[wr_i.wd] <= wr_i.wdata;
        end
    end

    assign rdata1_o = (raddr1_i == 5'd0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == 5'd0) ? '0 : regs[raddr2_i];

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile with verilator, then run; exit status is the testbench result

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f build.f --top-module tb_mips_core \
    -Mdir obj_dir -o tb_mips_core_sim &&
./obj_dir/tb_mips_core_sim ||
{
    echo "build or simulation failed" >&2
    exit 1
}

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    input  logic restart_i,
    output logic clk_o,
    output logic rst_n_o
);
    logic        clk_q = 1'b0;
    logic        rst_n_q = 1'b0;
    int unsigned hold_cnt = 0;

    // 4 ns period
    always #2 clk_q = ~clk_q;

    // reset low for 8 cycles after power up or a restart request
    always @(posedge clk_q) begin
        if (restart_i) begin
            hold_cnt <= 0;
            rst_n_q  <= 1'b0;
        end else if (hold_cnt < 7) begin
            hold_cnt <= hold_cnt + 1;
        end else begin
            rst_n_q <= 1'b1;
        end
    end

    assign clk_o   = clk_q;
    assign rst_n_o = rst_n_q;

endmodule

// ==== testbench/tb_mips_core.sv ====
`timescale 1ns/1ps

`include "mips_consts.svh"

module tb_mips_core;
    import mips_pkg::*;

    // five cycles per instruction plus twenty for each test
    localparam int TIMEOUT_CYCLES = (11 * 5 + 20) + (12 * 5 + 20) + (10 * 5 + 20)
                                  + (12 * 5 + 20) + (12 * 5 + 20) + (4 * 5 + 20);
    localparam int MEM_WORDS = 64;

    logic        clk;
    logic        rst_n;
    logic        restart = 1'b0;
    logic        wb_cyc;
    logic        wb_stb;
    word_t       wb_adr;
    inst_t       wb_dat = `MIPS_NOP_INST;
    logic        wb_ack = 1'b0;
    logic        commit_we;
    reg_addr_t   commit_addr;
    word_t       commit_data;

    inst_t       prog_mem [MEM_WORDS];
    int          prog_len = 0;
    word_t       ref_regs [32];
    logic [36:0] exp_q [$];
    word_t       exp_adr = '0;
    logic [31:0] lfsr_state = 32'h77da;
    int unsigned wait_left = 0;
    bit          zero_wait = 1'b0;
    int unsigned cycle_cnt = 0;

    tb_clock_gen clk_gen0 (
        .restart_i (restart),
        .clk_o     (clk),
        .rst_n_o   (rst_n)
    );

    mips_core_top dut0 (
        .clk           (clk),
        .rst_n_i       (rst_n),
        .wb_cyc_o      (wb_cyc),
        .wb_stb_o      (wb_stb),
        .wb_adr_o      (wb_adr),
        .wb_dat_i      (wb_dat),
        .wb_ack_i      (wb_ack),
        .commit_we_o   (commit_we),
        .commit_addr_o (commit_addr),
        .commit_data_o (commit_data)
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "run stopped at first failure");
    endtask

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int unsigned draw_wait();
        int unsigned w;
        w = 0;
        if (zero_wait) begin
            return 0;
        end
        for (int i = 0; i < 2; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[30:0], lfsr_state[0]};
        end
        return w;
    endfunction

    function automatic inst_t word_at(input word_t adr);
        int unsigned idx;
        idx = adr >> 2;
        if (idx < prog_len) begin
            return prog_mem[idx[5:0]];
        end
        return `MIPS_NOP_INST;
    endfunction

    function automatic inst_t rtype(input logic [5:0] fn, input int rd, input int rs,
                                    input int rt, input int sh);
        return {`MIPS_OP_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
    endfunction

    function automatic inst_t itype(input logic [5:0] op, input int rt, input int rs,
                                    input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    task automatic emit(input inst_t inst);
        prog_mem[prog_len[5:0]] = inst;
        prog_len++;
    endtask

    // registered ack after 0 to 3 idle cycles
    always @(posedge clk) begin
        word_t next_adr;
        next_adr = (wb_stb && wb_ack) ? wb_adr + 32'd4 : wb_adr;
        if (!rst_n) begin
            wb_ack    <= 1'b0;
            wait_left <= 0;
        end else if (wb_cyc && wb_stb && wait_left == 0) begin
            wb_ack    <= 1'b1;
            wb_dat    <= word_at(next_adr);
            wait_left <= draw_wait();
        end else begin
            wb_ack <= 1'b0;
            if (wait_left != 0) begin
                wait_left <= wait_left - 1;
            end
        end
    end

    always @(negedge clk) begin
        if (!rst_n) begin
            exp_adr = '0;
        end else if (wb_stb && wb_ack) begin
            assert (wb_adr == exp_adr)
                else fail_run($sformatf("** Error [%0t] fetch address %h, expected %h",
                                        $time, wb_adr, exp_adr));
            exp_adr = exp_adr + 32'd4;
        end
    end

    always @(negedge clk) begin
        logic [36:0] head;
        if (rst_n && commit_we) begin
            assert (exp_q.size() != 0)
                else fail_run($sformatf("commit to r%0d with no write left to expect",
                                        commit_addr));
            head = exp_q.pop_front();
            assert (commit_addr == head[36:32] && commit_data == head[31:0])
                else fail_run($sformatf("** Error [%0t] commit r%0d = %h, expected r%0d = %h",
                                        $time, commit_addr, commit_data,
                                        head[36:32], head[31:0]));
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            fail_run($sformatf("timeout, tests still running after %0d cycles", cycle_cnt));
        end
    end

    // ISA level model of the loaded program
    task automatic run_reference();
        inst_t      inst;
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] sh;
        logic [4:0] dst;
        word_t      a;
        word_t      b;
        word_t      zimm;
        word_t      simm;
        word_t      res;
        bit         wr;
        for (int i = 0; i < prog_len; i++) begin
            inst = prog_mem[i[5:0]];
            op   = inst[31:26];
            rs   = inst[25:21];
            rt   = inst[20:16];
            rd   = inst[15:11];
            sh   = inst[10:6];
            a    = ref_regs[rs];
            b    = ref_regs[rt];
            zimm = {16'h0000, inst[15:0]};
            simm = {{16{inst[15]}}, inst[15:0]};
            res  = '0;
            dst  = rt;
            wr   = 1'b1;
            if (op == `MIPS_OP_SPECIAL) begin
                dst = rd;
                case (inst[5:0])
                    `MIPS_FN_SLL:                res = b << sh;
                    `MIPS_FN_SRL:                res = b >> sh;
                    `MIPS_FN_SRA:                res = $unsigned($signed(b) >>> sh);
                    `MIPS_FN_SLLV:               res = b << a[4:0];
                    `MIPS_FN_SRLV:               res = b >> a[4:0];
                    `MIPS_FN_SRAV:               res = $unsigned($signed(b) >>> a[4:0]);
                    `MIPS_FN_ADD, `MIPS_FN_ADDU: res = a + b;
                    `MIPS_FN_SUB, `MIPS_FN_SUBU: res = a - b;
                    `MIPS_FN_AND:                res = a & b;
                    `MIPS_FN_OR:                 res = a | b;
                    `MIPS_FN_XOR:                res = a ^ b;
                    `MIPS_FN_NOR:                res = ~(a | b);
                    `MIPS_FN_SLT:                res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    `MIPS_FN_SLTU:               res = (a < b) ? 32'd1 : 32'd0;
                    default:                     wr = 1'b0;
                endcase
            end else begin
                case (op)
                    `MIPS_OP_ORI:   res = a | zimm;
                    `MIPS_OP_ANDI:  res = a & zimm;
                    `MIPS_OP_XORI:  res = a ^ zimm;
                    `MIPS_OP_LUI:   res = {inst[15:0], 16'h0000};
                    `MIPS_OP_ADDI:  res = a + simm;
                    `MIPS_OP_ADDIU: res = a + simm;
                    `MIPS_OP_SLTI:  res = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
                    `MIPS_OP_SLTIU: res = (a < simm) ? 32'd1 : 32'd0;
                    default:        wr = 1'b0;
                endcase
            end
            // r0 never takes a write
            if (wr && dst != 5'd0) begin
                ref_regs[dst] = res;
                exp_q.push_back({dst, res});
            end
        end
    endtask

    task automatic begin_test();
        restart <= 1'b1;
        @(posedge clk);
        restart <= 1'b0;
        prog_len = 0;
        exp_q.delete();
        for (int i = 0; i < 32; i++) begin
            ref_regs[i[4:0]] = '0;
        end
    endtask

    task automatic run_program();
        run_reference();
        @(negedge clk);
        assert (!rst_n && !wb_cyc && !wb_stb && !commit_we && wb_adr == '0)
            else fail_run($sformatf("** Error [%0t] bus or commit active during reset", $time));
        wait (rst_n == 1'b1);
        wait (exp_adr >= word_t'(prog_len * 4));
        repeat (8) @(posedge clk);
        assert (exp_q.size() == 0)
            else fail_run($sformatf("%0d expected register writes never committed",
                                    exp_q.size()));
    endtask

    task automatic logic_ops();
        begin_test();
        emit(itype(`MIPS_OP_ORI, 1, 0, 16'hf0f0));
        emit(itype(`MIPS_OP_LUI, 2, 0, 16'h1234));
        emit(itype(`MIPS_OP_ORI, 2, 2, 16'h8765));
        emit(itype(`MIPS_OP_LUI, 3, 0, 16'hff00));
        emit(rtype(`MIPS_FN_OR, 4, 1, 2, 0));
        emit(rtype(`MIPS_FN_AND, 5, 1, 2, 0));
        emit(rtype(`MIPS_FN_XOR, 6, 2, 3, 0));
        emit(rtype(`MIPS_FN_NOR, 7, 1, 3, 0));
        emit(itype(`MIPS_OP_ANDI, 8, 2, 16'h8f0f));
        emit(itype(`MIPS_OP_XORI, 9, 3, 16'h8001));
        emit(itype(`MIPS_OP_ORI, 10, 3, 16'h8000));
        run_program();
    endtask

    task automatic arith_wrap();
        begin_test();
        emit(itype(`MIPS_OP_LUI, 1, 0, 16'h7fff));
        emit(itype(`MIPS_OP_ORI, 1, 1, 16'hffff));
        emit(itype(`MIPS_OP_ADDI, 2, 0, 16'hffff));
        // wraps past the signed maximum
        emit(rtype(`MIPS_FN_ADD, 3, 1, 1, 0));
        emit(rtype(`MIPS_FN_ADDU, 4, 1, 2, 0));
        emit(rtype(`MIPS_FN_SUB, 5, 2, 1, 0));
        emit(rtype(`MIPS_FN_SUBU, 6, 0, 1, 0));
        emit(itype(`MIPS_OP_ADDIU, 7, 1, 16'h8000));
        emit(rtype(`MIPS_FN_SLT, 8, 2, 1, 0));
        emit(rtype(`MIPS_FN_SLTU, 9, 2, 1, 0));
        emit(itype(`MIPS_OP_SLTI, 10, 2, 16'h0000));
        emit(itype(`MIPS_OP_SLTIU, 11, 1, 16'hffff));
        run_program();
    endtask

    task automatic shift_amounts();
        begin_test();
        emit(itype(`MIPS_OP_LUI, 1, 0, 16'h8000));
        emit(itype(`MIPS_OP_ORI, 1, 1, 16'h00f1));
        // amount 36 of which only the low five bits count
        emit(itype(`MIPS_OP_ORI, 2, 0, 16'h0024));
        emit(rtype(`MIPS_FN_SLL, 3, 0, 1, 4));
        emit(rtype(`MIPS_FN_SRL, 4, 0, 1, 8));
        emit(rtype(`MIPS_FN_SRA, 5, 0, 1, 8));
        emit(rtype(`MIPS_FN_SLLV, 6, 2, 1, 0));
        emit(rtype(`MIPS_FN_SRLV, 7, 2, 1, 0));
        emit(rtype(`MIPS_FN_SRAV, 8, 2, 1, 0));
        emit(rtype(`MIPS_FN_SRA, 9, 0, 1, 31));
        run_program();
    endtask

    // no wait states so the distances hold in cycles too
    task automatic forward_chains();
        begin_test();
        zero_wait = 1'b1;
        emit(itype(`MIPS_OP_ORI, 1, 0, 16'h0005));
        emit(itype(`MIPS_OP_ADDI, 2, 1, 16'h0003));
        emit(rtype(`MIPS_FN_ADD, 3, 1, 2, 0));
        emit(rtype(`MIPS_FN_XOR, 4, 1, 3, 0));
        emit(itype(`MIPS_OP_ORI, 5, 0, 16'h0100));
        emit(`MIPS_NOP_INST);
        emit(rtype(`MIPS_FN_OR, 5, 5, 3, 0));
        emit(itype(`MIPS_OP_ADDI, 5, 5, 16'h0001));
        // newer r5 in execute must win over writeback
        emit(rtype(`MIPS_FN_ADDU, 7, 5, 5, 0));
        emit(`MIPS_NOP_INST);
        emit(`MIPS_NOP_INST);
        emit(rtype(`MIPS_FN_SUBU, 8, 7, 5, 0));
        run_program();
        zero_wait = 1'b0;
    endtask

    task automatic fetch_order();
        begin_test();
        emit(itype(`MIPS_OP_ORI, 0, 0, 16'h0055));
        emit(rtype(`MIPS_FN_ADD, 0, 1, 1, 0));
        emit(itype(`MIPS_OP_ORI, 1, 0, 16'h0001));
        emit(itype(`MIPS_OP_ADDIU, 2, 1, 16'h0001));
        emit(itype(`MIPS_OP_ADDIU, 3, 2, 16'h0001));
        // movz is dropped from this core
        emit(rtype(6'b001010, 4, 1, 2, 0));
        emit(itype(`MIPS_OP_ADDIU, 4, 3, 16'h0001));
        // reserved opcode naming r4 in both rt and rd
        emit(32'hfc04_2000);
        emit(itype(`MIPS_OP_ADDIU, 5, 4, 16'h0001));
        emit(rtype(`MIPS_FN_OR, 0, 5, 5, 0));
        emit(itype(`MIPS_OP_ADDIU, 6, 5, 16'h0001));
        emit(itype(`MIPS_OP_ADDIU, 7, 6, 16'h0001));
        run_program();
    endtask

    // registers written by earlier tests must read zero again
    task automatic reset_clear();
        begin_test();
        emit(rtype(`MIPS_FN_OR, 1, 5, 6, 0));
        emit(rtype(`MIPS_FN_OR, 2, 1, 7, 0));
        emit(rtype(`MIPS_FN_ADDU, 3, 4, 4, 0));
        emit(itype(`MIPS_OP_ORI, 4, 6, 16'h0000));
        run_program();
    endtask

    initial begin
        logic_ops();
        arith_wrap();
        shift_amounts();
        forward_chains();
        fetch_order();
        reset_clear();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule
